//--- cc_queue.f
hdl/cc_queue_pkg.sv
hdl/req_queue.sv
hdl/send_pacer.sv
hdl/dcqcn_rate_ctrl.sv
hdl/cc_queue.sv
verification/tb_clk_gen.sv
verification/cc_queue_checker.sv
verification/cc_queue_tb.sv

//--- Makefile
# Verilator build and run for the cc_queue testbench

VERILATOR  ?= verilator
FILELIST   ?= cc_queue.f
TB_TOP     ?= cc_queue_tb
RTL_TOP    ?= cc_queue
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run fails unless the pass message shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- verification/cc_queue_tb.sv
`timescale 1ns/1ps

module cc_queue_tb;

    import cc_queue_pkg::*;

    localparam int QDEPTH      = 16;
    localparam int DS_CREDITS  = 4;
    localparam int INIT_PERIOD = 8;

    logic                   aclk;
    logic                   aresetn;
    logic                   s_req_valid;
    req_opcode_t            s_req_opcode;
    logic [VADDR_BITS-1:0]  s_req_vaddr;
    logic [LEN_BITS-1:0]    s_req_len;
    logic                   s_credit;
    logic                   m_req_valid;
    req_opcode_t            m_req_opcode;
    logic [VADDR_BITS-1:0]  m_req_vaddr;
    logic [LEN_BITS-1:0]    m_req_len;
    logic                   m_credit;
    logic                   ecn_valid;
    logic                   ecn_mark;
    logic [PERIOD_BITS-1:0] cur_period;

    logic [2:0] phase;
    logic       report_req;
    logic       report_done;
    int         fail_total;

    int up_credits;
    int cycle;
    int pushes;
    int sends;
    bit ok;
    // cycles at which downstream returns a credit
    int due_q [$];

    tb_clk_gen clk_gen_i (
        .aclk(aclk),
        .aresetn(aresetn)
    );

    cc_queue #(
        .QDEPTH(QDEPTH),
        .DS_CREDITS(DS_CREDITS),
        .INIT_PERIOD(INIT_PERIOD)
    ) cc_queue_i (
        .aclk(aclk),
        .aresetn(aresetn),
        .s_req_valid(s_req_valid),
        .s_req_opcode(s_req_opcode),
        .s_req_vaddr(s_req_vaddr),
        .s_req_len(s_req_len),
        .s_credit(s_credit),
        .m_req_valid(m_req_valid),
        .m_req_opcode(m_req_opcode),
        .m_req_vaddr(m_req_vaddr),
        .m_req_len(m_req_len),
        .m_credit(m_credit),
        .ecn_valid(ecn_valid),
        .ecn_mark(ecn_mark),
        .cur_period(cur_period)
    );

    cc_queue_checker #(
        .DS_CREDITS(DS_CREDITS),
        .INIT_PERIOD(INIT_PERIOD)
    ) checker_i (
        .aclk(aclk),
        .aresetn(aresetn),
        .s_req_valid(s_req_valid),
        .s_req_opcode(s_req_opcode),
        .s_req_vaddr(s_req_vaddr),
        .s_req_len(s_req_len),
        .s_credit(s_credit),
        .m_req_valid(m_req_valid),
        .m_req_opcode(m_req_opcode),
        .m_req_vaddr(m_req_vaddr),
        .m_req_len(m_req_len),
        .m_credit(m_credit),
        .cur_period(cur_period),
        .phase(phase),
        .report_req(report_req),
        .report_done(report_done),
        .fail_total(fail_total)
    );

    // drives one cycle of stimulus on the falling edge
    task automatic drive_cycle(input logic [2:0] p, input int push_pct,
                               input int ecn_pct, input int mark_pct);
        @(negedge aclk);
        cycle++;
        phase = p;
        if (s_credit) up_credits++;
        if (m_req_valid) begin
            sends++;
            // long holds run the downstream credits dry
            due_q.push_back(cycle + 1 + int'($urandom % 100));
        end
        s_req_valid = 1'b0;
        if (up_credits > 0 && int'($urandom % 100) < push_pct) begin
            s_req_valid  = 1'b1;
            s_req_opcode = ($urandom % 2 == 0) ? OP_READ : OP_WRITE;
            s_req_vaddr  = VADDR_BITS'({$urandom, $urandom});
            s_req_len    = LEN_BITS'($urandom);
            up_credits--;
            pushes++;
        end
        m_credit = 1'b0;
        if (due_q.size() > 0 && due_q[0] <= cycle) begin
            m_credit = 1'b1;
            void'(due_q.pop_front());
        end
        ecn_valid = int'($urandom % 100) < ecn_pct;
        ecn_mark  = ecn_valid && (int'($urandom % 100) < mark_pct);
    endtask

    task automatic run_phase(input logic [2:0] p, input int cycles, input int push_pct,
                             input int ecn_pct, input int mark_pct);
        for (int i = 0; i < cycles; i++) begin
            drive_cycle(p, push_pct, ecn_pct, mark_pct);
        end
    endtask

    initial begin
        int n;
        s_req_valid  = 1'b0;
        s_req_opcode = OP_READ;
        s_req_vaddr  = '0;
        s_req_len    = '0;
        m_credit     = 1'b0;
        ecn_valid    = 1'b0;
        ecn_mark     = 1'b0;
        phase        = 3'd0;
        report_req   = 1'b0;
        up_credits   = QDEPTH;
        cycle        = 0;
        pushes       = 0;
        sends        = 0;
        ok           = 1'b1;
        void'($urandom(68825));

        n = 0;
        while (!aresetn && n < 50) begin
            drive_cycle(3'd0, 0, 0, 0);
            n++;
        end
        if (!aresetn) begin
            $display("timeout: reset was never released");
            ok = 1'b0;
        end

        if (ok) begin
            run_phase(3'd1, 300, 60, 30, 0);
            // heavy marking, then silence, then a mixed stream
            run_phase(3'd2, 160, 60, 50, 80);
            run_phase(3'd3, 2000, 60, 30, 0);
            run_phase(3'd4, 1500, 50, 20, 10);
            n = 0;
            while (sends < pushes && n < 20000) begin
                drive_cycle(3'd5, 0, 0, 0);
                n++;
            end
            if (sends < pushes) begin
                $display("timeout: the queue did not drain");
                ok = 1'b0;
            end
        end

        if (ok) begin
            run_phase(3'd5, 4, 0, 0, 0);
            report_req = 1'b1;
            n = 0;
            while (!report_done && n < 10) begin
                drive_cycle(3'd5, 0, 0, 0);
                n++;
            end
            if (!report_done) begin
                $display("timeout: the checker never reported");
                ok = 1'b0;
            end
        end

        if (ok && fail_total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- verification/cc_queue_checker.sv
`timescale 1ns/1ps

module cc_queue_checker #(
    parameter int DS_CREDITS  = 4,
    parameter int INIT_PERIOD = 8
) (
    input  logic                                  aclk,
    input  logic                                  aresetn,
    input  logic                                  s_req_valid,
    input  cc_queue_pkg::req_opcode_t             s_req_opcode,
    input  logic [cc_queue_pkg::VADDR_BITS-1:0]   s_req_vaddr,
    input  logic [cc_queue_pkg::LEN_BITS-1:0]     s_req_len,
    input  logic                                  s_credit,
    input  logic                                  m_req_valid,
    input  cc_queue_pkg::req_opcode_t             m_req_opcode,
    input  logic [cc_queue_pkg::VADDR_BITS-1:0]   m_req_vaddr,
    input  logic [cc_queue_pkg::LEN_BITS-1:0]     m_req_len,
    input  logic                                  m_credit,
    input  logic [cc_queue_pkg::PERIOD_BITS-1:0]  cur_period,
    input  logic [2:0]                            phase,
    input  logic                                  report_req,
    output logic                                  report_done,
    output int                                    fail_total
);

    import cc_queue_pkg::*;

    localparam int T_RESET  = 0;
    localparam int T_ORDER  = 1;
    localparam int T_CREDIT = 2;
    localparam int T_PACING = 3;
    localparam int T_CUT    = 4;
    localparam int T_RECOV  = 5;
    localparam int N_TESTS  = 6;

    int errs [N_TESTS];
    int tests_failed = 0;
    int total_errs = 0;

    // model FIFO of requests pushed but not yet sent
    req_opcode_t           exp_opcode [$];
    logic [VADDR_BITS-1:0] exp_vaddr  [$];
    logic [LEN_BITS-1:0]   exp_len    [$];

    int cyc = 0;
    int pushed = 0;
    int credited = 0;
    int sent_cnt = 0;
    int returned = 0;
    int last_send = 0;
    int prev_period = 0;
    bit seen_send = 1'b0;
    bit reset_checked = 1'b0;
    logic [2:0] last_phase = '0;
    logic [PERIOD_BITS-1:0] mark_end_period = '0;

    function automatic string test_name(input int t);
        case (t)
            T_RESET:  return "reset_state";
            T_ORDER:  return "order_integrity";
            T_CREDIT: return "credit_discipline";
            T_PACING: return "pacing";
            T_CUT:    return "congestion_cut";
            default:  return "recovery_bounds";
        endcase
    endfunction

    task automatic report_value(input int t, input string what,
                                input logic [63:0] exp, input logic [63:0] act);
        $display("ERROR %s: %s expected %0d, actual %0d", test_name(t), what, exp, act);
        errs[t]++;
        total_errs++;
    endtask

    task automatic report_event(input int t, input string msg);
        $display("%s: %s", test_name(t), msg);
        errs[t]++;
        total_errs++;
    endtask

    task automatic finish_test(input int t);
        if (errs[t] == 0) begin
            $display("PASS %s", test_name(t));
        end else begin
            $display("FAIL %s (%0d errors)", test_name(t), errs[t]);
            tests_failed++;
        end
    endtask

    always @(posedge aclk) begin
        if (!aresetn) begin
            report_done = 1'b0;
            fail_total  = 0;
        end else begin
            cyc++;
            if (!reset_checked) begin
                reset_checked = 1'b1;
                if (m_req_valid !== 1'b0) report_value(T_RESET, "m_req_valid", 0, m_req_valid);
                if (s_credit !== 1'b0) report_value(T_RESET, "s_credit", 0, s_credit);
                if (cur_period !== PERIOD_BITS'(INIT_PERIOD)) begin
                    report_value(T_RESET, "cur_period", INIT_PERIOD, cur_period);
                end
                finish_test(T_RESET);
            end

            // a send takes the oldest pending request
            if (m_req_valid) begin
                if (exp_opcode.size() == 0) begin
                    report_event(T_ORDER, "a request was sent while none was pending");
                end else begin
                    if (m_req_opcode !== exp_opcode[0]) begin
                        report_value(T_ORDER, "opcode", exp_opcode[0], m_req_opcode);
                    end
                    if (m_req_vaddr !== exp_vaddr[0]) begin
                        report_value(T_ORDER, "vaddr", exp_vaddr[0], m_req_vaddr);
                    end
                    if (m_req_len !== exp_len[0]) begin
                        report_value(T_ORDER, "len", exp_len[0], m_req_len);
                    end
                    void'(exp_opcode.pop_front());
                    void'(exp_vaddr.pop_front());
                    void'(exp_len.pop_front());
                end
                // pop decision used the period of the cycle before
                if (seen_send && (cyc - last_send < prev_period + 1)) begin
                    report_value(T_PACING, "min send gap", prev_period + 1, cyc - last_send);
                end
                seen_send = 1'b1;
                last_send = cyc;
                sent_cnt++;
            end
            if (s_req_valid) begin
                exp_opcode.push_back(s_req_opcode);
                exp_vaddr.push_back(s_req_vaddr);
                exp_len.push_back(s_req_len);
                pushed++;
            end

            if (s_credit) begin
                credited++;
                if (credited > pushed) report_value(T_CREDIT, "max s_credit", pushed, credited);
            end
            if (m_credit) returned++;
            if (sent_cnt - returned > DS_CREDITS) begin
                report_value(T_CREDIT, "max outstanding", DS_CREDITS, sent_cnt - returned);
            end

            if (cur_period < MIN_PERIOD) begin
                report_value(T_RECOV, "min cur_period", MIN_PERIOD, cur_period);
            end
            if (cur_period > MAX_PERIOD) begin
                report_value(T_RECOV, "max cur_period", MAX_PERIOD, cur_period);
            end

            // end of heavy marking
            if (last_phase == 3'd2 && phase == 3'd3) begin
                mark_end_period = cur_period;
                if (cur_period <= PERIOD_BITS'(INIT_PERIOD)) begin
                    report_value(T_CUT, "cur_period above", INIT_PERIOD + 1, cur_period);
                end
                finish_test(T_CUT);
            end
            // end of silence
            if (last_phase == 3'd3 && phase == 3'd4 && cur_period > mark_end_period) begin
                report_value(T_RECOV, "max cur_period after silence", mark_end_period, cur_period);
            end
            last_phase  = phase;
            prev_period = int'(cur_period);

            if (report_req && !report_done) begin
                if (exp_opcode.size() != 0) report_value(T_ORDER, "pending", 0, exp_opcode.size());
                if (credited != pushed) report_value(T_CREDIT, "s_credit total", pushed, credited);
                finish_test(T_ORDER);
                finish_test(T_CREDIT);
                finish_test(T_PACING);
                finish_test(T_RECOV);
                $display("tests: %0d, failed: %0d, errors: %0d", N_TESTS, tests_failed, total_errs);
                fail_total  = tests_failed;
                report_done = 1'b1;
            end
        end
    end

endmodule

//--- verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic aclk,
    output logic aresetn
);

    // 40 ns period
    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    // reset held over three rising edges, released on a falling edge
    initial begin
        aresetn = 1'b0;
        repeat (3) @(posedge aclk);
        @(negedge aclk);
        aresetn <= 1'b1;
    end

endmodule

//--- hdl/cc_queue.sv
`timescale 1ns/1ps

module cc_queue #(
    parameter int QDEPTH      = 16,
    parameter int DS_CREDITS  = 4,
    parameter int INIT_PERIOD = 8
) (
    input  logic                                  aclk,
    input  logic                                  aresetn,

    // upstream work requests
    input  logic                                  s_req_valid,
    input  cc_queue_pkg::req_opcode_t             s_req_opcode,
    input  logic [cc_queue_pkg::VADDR_BITS-1:0]   s_req_vaddr,
    input  logic [cc_queue_pkg::LEN_BITS-1:0]     s_req_len,
    output logic                                  s_credit,

    // downstream work requests
    output logic                                  m_req_valid,
    output cc_queue_pkg::req_opcode_t             m_req_opcode,
    output logic [cc_queue_pkg::VADDR_BITS-1:0]   m_req_vaddr,
    output logic [cc_queue_pkg::LEN_BITS-1:0]     m_req_len,
    input  logic                                  m_credit,

    // congestion feedback
    input  logic                                  ecn_valid,
    input  logic                                  ecn_mark,

    output logic [cc_queue_pkg::PERIOD_BITS-1:0]  cur_period
);

    import cc_queue_pkg::*;

    logic                  q_valid;
    req_opcode_t           q_opcode;
    logic [VADDR_BITS-1:0] q_vaddr;
    logic [LEN_BITS-1:0]   q_len;
    logic                  q_pop;
    logic                  sent;

    req_queue #(
        .QDEPTH(QDEPTH)
    ) req_queue_i (
        .aclk(aclk),
        .aresetn(aresetn),
        .push(s_req_valid),
        .push_opcode(s_req_opcode),
        .push_vaddr(s_req_vaddr),
        .push_len(s_req_len),
        .pop(q_pop),
        .q_valid(q_valid),
        .q_opcode(q_opcode),
        .q_vaddr(q_vaddr),
        .q_len(q_len),
        .credit(s_credit)
    );

    send_pacer #(
        .DS_CREDITS(DS_CREDITS)
    ) send_pacer_i (
        .aclk(aclk),
        .aresetn(aresetn),
        .q_valid(q_valid),
        .q_opcode(q_opcode),
        .q_vaddr(q_vaddr),
        .q_len(q_len),
        .q_pop(q_pop),
        .cur_period(cur_period),
        .m_credit(m_credit),
        .m_req_valid(m_req_valid),
        .m_req_opcode(m_req_opcode),
        .m_req_vaddr(m_req_vaddr),
        .m_req_len(m_req_len),
        .sent(sent)
    );

    dcqcn_rate_ctrl #(
        .INIT_PERIOD(INIT_PERIOD)
    ) dcqcn_rate_ctrl_i (
        .aclk(aclk),
        .aresetn(aresetn),
        .ecn_valid(ecn_valid),
        .ecn_mark(ecn_mark),
        .sent(sent),
        .cur_period(cur_period)
    );

endmodule

//--- hdl/dcqcn_rate_ctrl.sv
`timescale 1ns/1ps

module dcqcn_rate_ctrl #(
    parameter int INIT_PERIOD = 8
) (
    input  logic                                  aclk,
    input  logic                                  aresetn,

    input  logic                                  ecn_valid,
    input  logic                                  ecn_mark,
    input  logic                                  sent,

    output logic [cc_queue_pkg::PERIOD_BITS-1:0]  cur_period
);

    import cc_queue_pkg::*;

    localparam logic [PERIOD_BITS-1:0] INIT_P = PERIOD_BITS'(INIT_PERIOD);

    logic [PERIOD_BITS-1:0] target_period;
    logic [ALPHA_BITS-1:0]  alpha;
    rc_state_t              rc_state;
    logic [2:0]             step_cnt;

    // cycles since last cut, saturating
    logic [PERIOD_BITS-1:0] gap_cnt;
    // cycles since last mark
    logic [PERIOD_BITS-1:0] silence_cnt;
    // recovery event sources
    logic [PERIOD_BITS-1:0] rec_timer;
    logic [PERIOD_BITS-1:0] send_cnt;

    logic mark;
    logic cut;
    logic decay;
    logic rec_event;

    logic [PERIOD_BITS+ALPHA_BITS-1:0] cut_prod;
    logic [PERIOD_BITS:0]              cut_step;
    logic [PERIOD_BITS:0]              grown;
    logic [PERIOD_BITS-1:0]            ai_target;
    logic [PERIOD_BITS-1:0]            rec_target;
    logic [PERIOD_BITS:0]              mid_sum;

    logic [2*ALPHA_BITS-1:0] rise_prod;
    logic [2*ALPHA_BITS-1:0] decay_prod;
    logic [ALPHA_BITS-1:0]   alpha_rise;
    logic [ALPHA_BITS-1:0]   alpha_decay;

    function automatic logic [PERIOD_BITS-1:0] clamp_period(input logic [PERIOD_BITS:0] p);
        logic [PERIOD_BITS-1:0] r;
        if (p > {1'b0, MAX_PERIOD}) begin
            r = MAX_PERIOD;
        end else if (p < {1'b0, MIN_PERIOD}) begin
            r = MIN_PERIOD;
        end else begin
            r = p[PERIOD_BITS-1:0];
        end
        return r;
    endfunction

    assign mark      = ecn_valid && ecn_mark;
    assign cut       = mark && (gap_cnt >= MIN_MARK_GAP);
    assign decay     = !mark && (silence_cnt == MIN_MARK_GAP - 1'b1);
    assign rec_event = (rec_timer == RECOVERY_CYCLES - 1'b1) ||
                       (sent && (send_cnt == RECOVERY_SENDS - 1'b1));

    // decrease: period grows by period * alpha / 2
    always_comb begin
        cut_prod = cur_period * alpha;
        cut_step = cut_prod[PERIOD_BITS+ALPHA_BITS-1:9];
        if (cut_step == '0) begin
            cut_step = 1;
        end
        grown = {1'b0, cur_period} + cut_step;
    end

    // recovery: additive phase lowers the target first
    always_comb begin
        if (target_period > MIN_PERIOD + AI_STEP) begin
            ai_target = target_period - AI_STEP;
        end else begin
            ai_target = MIN_PERIOD;
        end
        rec_target = (rc_state == RC_ADDITIVE) ? ai_target : target_period;
        mid_sum    = {1'b0, cur_period} + {1'b0, rec_target};
    end

    // alpha += g * (1 - alpha) on cut, alpha -= g * alpha on decay
    always_comb begin
        rise_prod   = (ALPHA_ONE - alpha) * ALPHA_G;
        decay_prod  = alpha * ALPHA_G;
        alpha_rise  = alpha + rise_prod[ALPHA_BITS+7:8];
        alpha_decay = alpha - decay_prod[ALPHA_BITS+7:8];
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            cur_period    <= INIT_P;
            target_period <= INIT_P;
            alpha         <= ALPHA_ONE;
            rc_state      <= RC_FAST_RECOVERY;
            step_cnt      <= '0;
            // first mark after reset may cut at once
            gap_cnt       <= MIN_MARK_GAP;
            silence_cnt   <= '0;
            rec_timer     <= '0;
            send_cnt      <= '0;
        end else begin
            if (gap_cnt != '1) begin
                gap_cnt <= gap_cnt + 1'b1;
            end

            if (mark || decay) begin
                silence_cnt <= '0;
            end else begin
                silence_cnt <= silence_cnt + 1'b1;
            end

            if (cut) begin
                target_period <= cur_period;
                cur_period    <= clamp_period(grown);
                alpha         <= alpha_rise;
                rc_state      <= RC_FAST_RECOVERY;
                step_cnt      <= '0;
                gap_cnt       <= '0;
                rec_timer     <= '0;
                send_cnt      <= '0;
            end else begin
                if (decay) begin
                    alpha <= alpha_decay;
                end
                if (rec_event) begin
                    rec_timer     <= '0;
                    send_cnt      <= '0;
                    target_period <= rec_target;
                    cur_period    <= clamp_period({1'b0, mid_sum[PERIOD_BITS:1]});
                    if (rc_state == RC_FAST_RECOVERY) begin
                        step_cnt <= step_cnt + 1'b1;
                        if (step_cnt == F_STEPS - 1'b1) begin
                            rc_state <= RC_ADDITIVE;
                        end
                    end
                end else begin
                    rec_timer <= rec_timer + 1'b1;
                    if (sent) begin
                        send_cnt <= send_cnt + 1'b1;
                    end
                end
            end
        end
    end

    // period stays inside the clamp whatever the ECN stream does
    assert property (@(posedge aclk) disable iff (!aresetn)
        (cur_period >= MIN_PERIOD) && (cur_period <= MAX_PERIOD));

endmodule

//--- hdl/send_pacer.sv
`timescale 1ns/1ps

module send_pacer #(
    parameter int DS_CREDITS = 4
) (
    input  logic                                  aclk,
    input  logic                                  aresetn,

    input  logic                                  q_valid,
    input  cc_queue_pkg::req_opcode_t             q_opcode,
    input  logic [cc_queue_pkg::VADDR_BITS-1:0]   q_vaddr,
    input  logic [cc_queue_pkg::LEN_BITS-1:0]     q_len,
    output logic                                  q_pop,

    input  logic [cc_queue_pkg::PERIOD_BITS-1:0]  cur_period,

    input  logic                                  m_credit,
    output logic                                  m_req_valid,
    output cc_queue_pkg::req_opcode_t             m_req_opcode,
    output logic [cc_queue_pkg::VADDR_BITS-1:0]   m_req_vaddr,
    output logic [cc_queue_pkg::LEN_BITS-1:0]     m_req_len,

    output logic                                  sent
);

    import cc_queue_pkg::*;

    localparam int CRED_W = $clog2(DS_CREDITS + 1);
    localparam logic [CRED_W-1:0] INIT_CREDITS = CRED_W'(DS_CREDITS);

    logic [CRED_W-1:0]      credit_cnt;
    logic [PERIOD_BITS-1:0] gap_cnt;

    // pop when a head is waiting, a credit is free and the period has elapsed
    assign q_pop = q_valid && (credit_cnt != '0) && (gap_cnt >= cur_period);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            credit_cnt  <= INIT_CREDITS;
            gap_cnt     <= '0;
            m_req_valid <= 1'b0;
        end else begin
            m_req_valid <= q_pop;
            // credit is consumed in the send cycle
            if (m_req_valid && !m_credit) begin
                credit_cnt <= credit_cnt - 1'b1;
            end else if (m_credit && !m_req_valid) begin
                credit_cnt <= credit_cnt + 1'b1;
            end
            // gap reads zero in the send cycle
            if (q_pop) begin
                gap_cnt <= '0;
            end else if (gap_cnt != '1) begin
                gap_cnt <= gap_cnt + 1'b1;
            end
        end
    end

    // head fields captured on pop
    always_ff @(posedge aclk) begin
        if (q_pop) begin
            m_req_opcode <= q_opcode;
            m_req_vaddr  <= q_vaddr;
            m_req_len    <= q_len;
        end
    end

    assign sent = m_req_valid;

    // downstream never returns more than it was granted
    assert property (@(posedge aclk) disable iff (!aresetn) credit_cnt <= INIT_CREDITS);

    assert property (@(posedge aclk) disable iff (!aresetn)
        m_req_valid |-> (credit_cnt != '0));

endmodule

//--- hdl/req_queue.sv
`timescale 1ns/1ps

module req_queue #(
    parameter int QDEPTH = 16
) (
    input  logic                                 aclk,
    input  logic                                 aresetn,

    input  logic                                 push,
    input  cc_queue_pkg::req_opcode_t            push_opcode,
    input  logic [cc_queue_pkg::VADDR_BITS-1:0]  push_vaddr,
    input  logic [cc_queue_pkg::LEN_BITS-1:0]    push_len,

    input  logic                                 pop,

    output logic                                 q_valid,
    output cc_queue_pkg::req_opcode_t            q_opcode,
    output logic [cc_queue_pkg::VADDR_BITS-1:0]  q_vaddr,
    output logic [cc_queue_pkg::LEN_BITS-1:0]    q_len,

    output logic                                 credit
);

    import cc_queue_pkg::*;

    localparam int PTR_W = (QDEPTH > 1) ? $clog2(QDEPTH) : 1;
    localparam int CNT_W = $clog2(QDEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(QDEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(QDEPTH);

    // request storage, one array per field
    req_opcode_t           mem_opcode [QDEPTH];
    logic [VADDR_BITS-1:0] mem_vaddr  [QDEPTH];
    logic [LEN_BITS-1:0]   mem_len    [QDEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    always_ff @(posedge aclk) begin
        if (push) begin
            mem_opcode[wr_ptr] <= push_opcode;
            mem_vaddr[wr_ptr]  <= push_vaddr;
            mem_len[wr_ptr]    <= push_len;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
            // one credit back upstream per dequeue
            credit <= pop;
        end
    end

    // head of queue
    assign q_valid  = (count != '0);
    assign q_opcode = mem_opcode[rd_ptr];
    assign q_vaddr  = mem_vaddr[rd_ptr];
    assign q_len    = mem_len[rd_ptr];

    // upstream must respect its credits
    assert property (@(posedge aclk) disable iff (!aresetn) push |-> (count != FULL_CNT));

    // pacer only pops a valid head
    assert property (@(posedge aclk) disable iff (!aresetn) pop |-> (count != '0));

endmodule

//--- hdl/cc_queue_pkg.sv
package cc_queue_pkg;

    // work request opcodes
    typedef enum logic [0:0] {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } req_opcode_t;

    // request fields
    localparam int VADDR_BITS  = 48;
    localparam int LEN_BITS    = 28;

    // periods and cycle timers
    localparam int PERIOD_BITS = 24;

    // alpha is fixed point with 8 fraction bits
    localparam int ALPHA_BITS  = 10;

    localparam logic [ALPHA_BITS-1:0] ALPHA_ONE = 10'd256;
    // g = 1/16
    localparam logic [ALPHA_BITS-1:0] ALPHA_G   = 10'd16;

    // min spacing between cuts, also the alpha decay interval
    localparam logic [PERIOD_BITS-1:0] MIN_MARK_GAP    = 24'd32;
    localparam logic [PERIOD_BITS-1:0] RECOVERY_CYCLES = 24'd64;
    localparam logic [PERIOD_BITS-1:0] RECOVERY_SENDS  = 24'd8;
    localparam logic [PERIOD_BITS-1:0] AI_STEP         = 24'd1;
    localparam logic [PERIOD_BITS-1:0] MIN_PERIOD      = 24'd2;
    localparam logic [PERIOD_BITS-1:0] MAX_PERIOD      = 24'd1024;

    // rate controller phase after a cut
    typedef enum logic [0:0] {
        RC_FAST_RECOVERY = 1'b0,
        RC_ADDITIVE      = 1'b1
    } rc_state_t;

    // recovery events spent in fast recovery
    localparam logic [2:0] F_STEPS = 3'd5;

endpackage
